/* bench/mesh_read_tb.sv */
`timescale 1ns/1ps

// Table-driven testbench for the mesh read interface top level
// Writes segments, then issues reads with and without idle gaps
// An in-order scoreboard checks every response against a bank model

module mesh_read_tb;
    import mri_pkg::*;

    localparam int N_WR        = 10;                          // Write table size
    localparam int N_WR_INIT   = 8;                           // Entries before the rewrite
    localparam int N_RD        = 12;                          // Read table size
    localparam int DRAIN_LIMIT = N_RD * (2 * FIFO_DEPTH + MEM_RD_LAT + 4);

    logic                 clk;
    logic                 rst_n;
    logic                 rreq_valid;
    logic [W_SEG_PTR-1:0] rreq_seg_ptr;
    logic [W_SEMA-1:0]    rreq_sema;
    logic [W_WD_SEL-1:0]  rreq_wd_sel;
    logic [W_REQ_ID-1:0]  rreq_id;
    logic                 wr_valid;
    logic [W_SEG_PTR-1:0] wr_seg_ptr;
    logic [W_SEMA-1:0]    wr_sema;
    logic [W_WD_SEL-1:0]  wr_wd_sel;
    logic [W_WORD-1:0]    wr_data;
    logic                 rrsp_valid;
    logic [W_WORD-1:0]    rrsp_data;
    logic [W_REQ_ID-1:0]  rrsp_id;
    logic                 rrsp_err;
    logic                 rreq_overflow;
    logic                 rrsp_overflow;

    ////////////////////////////////////////////////////////////
    // Stimulus tables
    ////////////////////////////////////////////////////////////
    // Write entry is {seg, sema, wd_sel, data}
    // Last two entries rewrite segments 7 and 3
    logic [W_SEG_PTR+W_SEMA+W_WD_SEL+W_WORD-1:0] wr_tab [N_WR] = '{
        {4'd3,  2'd1, 2'd0, 32'hA5A5_0300},
        {4'd3,  2'd1, 2'd2, 32'h1234_5678},
        {4'd7,  2'd2, 2'd1, 32'hDEAD_BEEF},
        {4'd7,  2'd2, 2'd3, 32'h0BAD_F00D},
        {4'd12, 2'd3, 2'd0, 32'hCAFE_0C00},
        {4'd12, 2'd3, 2'd3, 32'h5A5A_A5A5},
        {4'd0,  2'd0, 2'd1, 32'h0000_0001},
        {4'd15, 2'd1, 2'd2, 32'hFFFF_FFFE},
        {4'd7,  2'd3, 2'd1, 32'h7777_0001},               // New semaphore on seg 7
        {4'd3,  2'd2, 2'd0, 32'h3333_2000}                // New semaphore on seg 3
    };

    // Read entry is {seg, sema, wd_sel, id}
    logic [W_RREQ-1:0] rd_tab [N_RD] = '{
        {4'd3,  2'd1, 2'd0, 4'd1},
        {4'd3,  2'd1, 2'd2, 4'd2},
        {4'd7,  2'd2, 2'd1, 4'd3},
        {4'd7,  2'd2, 2'd3, 4'd4},
        {4'd7,  2'd3, 2'd1, 4'd5},                        // Stale until the rewrite
        {4'd12, 2'd3, 2'd0, 4'd6},
        {4'd12, 2'd1, 2'd3, 4'd7},                        // Always a semaphore miss
        {4'd0,  2'd0, 2'd1, 4'd8},
        {4'd15, 2'd1, 2'd2, 4'd9},
        {4'd3,  2'd2, 2'd0, 4'd10},
        {4'd12, 2'd3, 2'd3, 4'd11},
        {4'd15, 2'd0, 2'd2, 4'd12}
    };

    // Bank model kept in step with the applied writes
    logic [W_SEMA-1:0]   model_sema [N_SEG];
    logic [W_WORD-1:0]   model_word [N_SEG][N_WD_PER_SEG];

    // In-order scoreboard of expected responses
    logic [W_WORD-1:0]   exp_data [$];
    logic [W_REQ_ID-1:0] exp_id   [$];
    logic                exp_err  [$];
    int                  sent_cnt = 0;
    int                  rcvd_cnt = 0;
    logic [15:0]         lfsr_q   = 16'd25795;            // Gap generator state

    mesh_read_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .rreq_valid    (rreq_valid),
        .rreq_seg_ptr  (rreq_seg_ptr),
        .rreq_sema     (rreq_sema),
        .rreq_wd_sel   (rreq_wd_sel),
        .rreq_id       (rreq_id),
        .wr_valid      (wr_valid),
        .wr_seg_ptr    (wr_seg_ptr),
        .wr_sema       (wr_sema),
        .wr_wd_sel     (wr_wd_sel),
        .wr_data       (wr_data),
        .rrsp_valid    (rrsp_valid),
        .rrsp_data     (rrsp_data),
        .rrsp_id       (rrsp_id),
        .rrsp_err      (rrsp_err),
        .rreq_overflow (rreq_overflow),
        .rrsp_overflow (rrsp_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                            // 10 ns period
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [W_WORD-1:0] want,
                               input logic [W_WORD-1:0] got);
        assert (got === want) else
            abort_run($sformatf("ERROR at %0t: %s expected 0x%0h, got 0x%0h",
                                $time, name, want, got));
    endtask

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bit(output logic b);
        b      = lfsr_q[15];
        lfsr_q = lfsr_next(lfsr_q);                       // One step per bit taken
    endtask

    task automatic apply_writes(input int first, input int last);
        logic [W_SEG_PTR-1:0] seg;
        logic [W_SEMA-1:0]    sema;
        logic [W_WD_SEL-1:0]  wd;
        logic [W_WORD-1:0]    data;
        for (int i = first; i <= last; i++) begin
            {seg, sema, wd, data} = wr_tab[i];
            @(posedge clk);
            wr_valid   <= 1'b1;
            wr_seg_ptr <= seg;
            wr_sema    <= sema;
            wr_wd_sel  <= wd;
            wr_data    <= data;
            model_sema[seg]     = sema;                   // Write sets the segment semaphore
            model_word[seg][wd] = data;
        end
        @(posedge clk);
        wr_valid <= 1'b0;
    endtask

    // Issues the whole read table with optional LFSR gaps of 0..3 cycles
    task automatic send_reads(input logic use_gaps);
        logic [W_SEG_PTR-1:0] seg;
        logic [W_SEMA-1:0]    sema;
        logic [W_WD_SEL-1:0]  wd;
        logic [W_REQ_ID-1:0]  id;
        logic                 b0;
        logic                 b1;
        for (int i = 0; i < N_RD; i++) begin
            {seg, sema, wd, id} = rd_tab[i];
            @(posedge clk);
            rreq_valid   <= 1'b1;
            rreq_seg_ptr <= seg;
            rreq_sema    <= sema;
            rreq_wd_sel  <= wd;
            rreq_id      <= id;
            if (model_sema[seg] == sema) begin            // Semaphore hit returns the word
                exp_data.push_back(model_word[seg][wd]);
                exp_err.push_back(1'b0);
            end else begin                                // Miss returns err and zero data
                exp_data.push_back('0);
                exp_err.push_back(1'b1);
            end
            exp_id.push_back(id);
            sent_cnt++;
            if (use_gaps) begin
                draw_bit(b0);
                draw_bit(b1);
                repeat ({b1, b0}) begin
                    @(posedge clk);
                    rreq_valid <= 1'b0;
                end
            end
        end
        @(posedge clk);
        rreq_valid <= 1'b0;
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (rcvd_cnt < sent_cnt && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        assert (rcvd_cnt == sent_cnt) else
            abort_run($sformatf("Timeout: %0d of %0d read responses never arrived",
                                sent_cnt - rcvd_cnt, sent_cnt));
    endtask

    ////////////////////////////////////////////////////////////
    // Response monitor
    ////////////////////////////////////////////////////////////
    // Samples on the falling edge while DUT outputs are settled
    always @(negedge clk) begin : rsp_monitor
        logic [W_WORD-1:0]   want_data;
        logic [W_REQ_ID-1:0] want_id;
        logic                want_err;
        if (rst_n) begin
            check_field("rreq_overflow", '0, W_WORD'(rreq_overflow));
            check_field("rrsp_overflow", '0, W_WORD'(rrsp_overflow));
            if (rrsp_valid) begin
                assert (exp_id.size() > 0) else
                    abort_run("A response arrived with no read outstanding");
                want_data = exp_data.pop_front();
                want_id   = exp_id.pop_front();
                want_err  = exp_err.pop_front();
                check_field("rrsp_id", W_WORD'(want_id), W_WORD'(rrsp_id));
                check_field("rrsp_err", W_WORD'(want_err), W_WORD'(rrsp_err));
                check_field("rrsp_data", want_data, rrsp_data);
                rcvd_cnt++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin : stimulus
        rst_n        = 1'b0;
        rreq_valid   = 1'b0;
        rreq_seg_ptr = '0;
        rreq_sema    = '0;
        rreq_wd_sel  = '0;
        rreq_id      = '0;
        wr_valid     = 1'b0;
        wr_seg_ptr   = '0;
        wr_sema      = '0;
        wr_wd_sel    = '0;
        wr_data      = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Nothing comes out of an idle path
        repeat (8) begin
            @(negedge clk);
            check_field("rrsp_valid", '0, W_WORD'(rrsp_valid));
        end

        apply_writes(0, N_WR_INIT - 1);
        send_reads(1'b0);                                 // Back to back
        wait_drained();
        send_reads(1'b1);                                 // Random gaps
        wait_drained();

        // Rewrite flips which semaphores hit on segments 7 and 3
        apply_writes(N_WR_INIT, N_WR - 1);
        send_reads(1'b1);
        wait_drained();

        repeat (10) @(posedge clk);                       // Room for any stray duplicate
        $display("** PASS **");
        $finish;
    end

endmodule : mesh_read_tb

/* hdl/mesh_read_top.sv */
`timescale 1ns/1ps

// Mesh read interface for the egress path
// Request queue feeds the word bank, bank responses are queued out with their IDs

module mesh_read_top (
    input  logic                          clk,
    input  logic                          rst_n,

    // Word read requests from the packet read controller
    input  logic                          rreq_valid,
    input  logic [mri_pkg::W_SEG_PTR-1:0] rreq_seg_ptr,
    input  logic [mri_pkg::W_SEMA-1:0]    rreq_sema,
    input  logic [mri_pkg::W_WD_SEL-1:0]  rreq_wd_sel,
    input  logic [mri_pkg::W_REQ_ID-1:0]  rreq_id,

    // Segment writes into the bank
    input  logic                          wr_valid,
    input  logic [mri_pkg::W_SEG_PTR-1:0] wr_seg_ptr,
    input  logic [mri_pkg::W_SEMA-1:0]    wr_sema,
    input  logic [mri_pkg::W_WD_SEL-1:0]  wr_wd_sel,
    input  logic [mri_pkg::W_WORD-1:0]    wr_data,

    // Responses to transmit queuing
    output logic                          rrsp_valid,
    output logic [mri_pkg::W_WORD-1:0]    rrsp_data,
    output logic [mri_pkg::W_REQ_ID-1:0]  rrsp_id,
    output logic                          rrsp_err,

    output logic                          rreq_overflow,  // Request queue dropped an entry
    output logic                          rrsp_overflow   // Response queue dropped an entry
);
    import mri_pkg::*;

    logic [W_RREQ-1:0]    rreq_d_in;
    logic [W_RREQ-1:0]    rreq_d_out;
    logic                 mem_rreq_valid;
    logic [W_SEG_PTR-1:0] mem_rreq_seg_ptr;
    logic [W_SEMA-1:0]    mem_rreq_sema;
    logic [W_WD_SEL-1:0]  mem_rreq_wd_sel;
    logic [W_REQ_ID-1:0]  mem_rreq_id;

    logic [W_RRSP-1:0]    rrsp_d_in;
    logic [W_RRSP-1:0]    rrsp_d_out;
    logic                 mem_rrsp_valid;
    logic [W_WORD-1:0]    mem_rrsp_data;
    logic [W_REQ_ID-1:0]  mem_rrsp_id;
    logic                 mem_rrsp_err;

    ////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////
    assign rreq_d_in = {rreq_seg_ptr, rreq_sema, rreq_wd_sel, rreq_id};

    mri_drain_fifo #(.WIDTH(W_RREQ)) rreq_fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (rreq_valid),
        .d_in      (rreq_d_in),
        .valid_out (mem_rreq_valid),      // Issue strobe to the bank
        .d_out     (rreq_d_out),
        .overflow  (rreq_overflow)
    );

    assign {mem_rreq_seg_ptr, mem_rreq_sema, mem_rreq_wd_sel, mem_rreq_id} = rreq_d_out;

    ////////////////////////////////////////////////////////////
    // Word bank
    ////////////////////////////////////////////////////////////
    mesh_word_bank word_bank_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .wr_valid         (wr_valid),
        .wr_seg_ptr       (wr_seg_ptr),
        .wr_sema          (wr_sema),
        .wr_wd_sel        (wr_wd_sel),
        .wr_data          (wr_data),
        .mem_rreq_valid   (mem_rreq_valid),
        .mem_rreq_seg_ptr (mem_rreq_seg_ptr),
        .mem_rreq_sema    (mem_rreq_sema),
        .mem_rreq_wd_sel  (mem_rreq_wd_sel),
        .mem_rreq_id      (mem_rreq_id),
        .mem_rrsp_valid   (mem_rrsp_valid),
        .mem_rrsp_data    (mem_rrsp_data),
        .mem_rrsp_id      (mem_rrsp_id),
        .mem_rrsp_err     (mem_rrsp_err)
    );

    ////////////////////////////////////////////////////////////
    // Output side
    ////////////////////////////////////////////////////////////
    assign rrsp_d_in = {mem_rrsp_err, mem_rrsp_id, mem_rrsp_data};

    mri_drain_fifo #(.WIDTH(W_RRSP)) rrsp_fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (mem_rrsp_valid),
        .d_in      (rrsp_d_in),
        .valid_out (rrsp_valid),
        .d_out     (rrsp_d_out),
        .overflow  (rrsp_overflow)
    );

    assign {rrsp_err, rrsp_id, rrsp_data} = rrsp_d_out;  // Fields qualified by rrsp_valid

endmodule : mesh_read_top

/* hdl/mesh_word_bank.sv */
`timescale 1ns/1ps

// Storage model of one row and line of the packet mesh
// Holds segment words plus one semaphore per segment, set by each write
// Reads are pipelined over MEM_RD_LAT cycles, a semaphore miss returns err and zero data

module mesh_word_bank (
    input  logic                          clk,
    input  logic                          rst_n,

    // Write port
    input  logic                          wr_valid,
    input  logic [mri_pkg::W_SEG_PTR-1:0] wr_seg_ptr,
    input  logic [mri_pkg::W_SEMA-1:0]    wr_sema,      // New semaphore for the segment
    input  logic [mri_pkg::W_WD_SEL-1:0]  wr_wd_sel,
    input  logic [mri_pkg::W_WORD-1:0]    wr_data,

    // Read request
    input  logic                          mem_rreq_valid,
    input  logic [mri_pkg::W_SEG_PTR-1:0] mem_rreq_seg_ptr,
    input  logic [mri_pkg::W_SEMA-1:0]    mem_rreq_sema,  // Must match the stored one
    input  logic [mri_pkg::W_WD_SEL-1:0]  mem_rreq_wd_sel,
    input  logic [mri_pkg::W_REQ_ID-1:0]  mem_rreq_id,

    // Read response
    output logic                          mem_rrsp_valid,
    output logic [mri_pkg::W_WORD-1:0]    mem_rrsp_data,
    output logic [mri_pkg::W_REQ_ID-1:0]  mem_rrsp_id,
    output logic                          mem_rrsp_err
);
    import mri_pkg::*;

    logic [W_WORD-1:0]   word_mem [N_SEG][N_WD_PER_SEG];  // Segment words
    logic [W_SEMA-1:0]   seg_sema [N_SEG];                // Current semaphore per segment

    // Stage 0 lookup
    logic [W_WORD-1:0]   rd_word;
    logic                rd_sema_ok;
    bank_op_e            cur_op;

    // Read pipe, index 0 is the lookup stage
    logic                vld_q  [MEM_RD_LAT];
    bank_op_e            op_q   [MEM_RD_LAT];
    logic [W_REQ_ID-1:0] id_q   [MEM_RD_LAT];
    logic [W_WORD-1:0]   data_q [MEM_RD_LAT];
    logic                err_q  [MEM_RD_LAT];

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_valid) begin
            word_mem[wr_seg_ptr][wr_wd_sel] <= wr_data;
        end
    end

    // Semaphores start at zero so early reads compare against a known value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < N_SEG; s++) begin
                seg_sema[s] <= '0;
            end
        end else if (wr_valid) begin
            seg_sema[wr_seg_ptr] <= wr_sema;              // Last write owns the segment
        end
    end

    ////////////////////////////////////////////////////////////
    // Lookup and semaphore check
    ////////////////////////////////////////////////////////////
    // Reads old contents when a write lands on the same edge
    assign rd_word    = word_mem[mem_rreq_seg_ptr][mem_rreq_wd_sel];
    assign rd_sema_ok = (seg_sema[mem_rreq_seg_ptr] == mem_rreq_sema);

    always_comb begin
        if (mem_rreq_valid) begin
            cur_op = OP_READ;
        end else if (wr_valid) begin
            cur_op = OP_WRITE;
        end else begin
            cur_op = OP_IDLE;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read pipe
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_RD_LAT; i++) begin
                vld_q[i] <= 1'b0;
                op_q[i]  <= OP_IDLE;
            end
        end else begin
            vld_q[0] <= mem_rreq_valid || wr_valid;       // Bank busy this cycle
            op_q[0]  <= cur_op;
            for (int i = 1; i < MEM_RD_LAT; i++) begin
                vld_q[i] <= vld_q[i-1];
                op_q[i]  <= op_q[i-1];
            end
        end
    end

    // Payload follows the control bits down the pipe
    always_ff @(posedge clk) begin
        if (mem_rreq_valid) begin
            id_q[0]   <= mem_rreq_id;
            data_q[0] <= rd_sema_ok ? rd_word : '0;      // Zero data on a stale handle
            err_q[0]  <= !rd_sema_ok;
        end
        for (int i = 1; i < MEM_RD_LAT; i++) begin
            id_q[i]   <= id_q[i-1];
            data_q[i] <= data_q[i-1];
            err_q[i]  <= err_q[i-1];
        end
    end

    // Only reads produce a response
    assign mem_rrsp_valid = vld_q[MEM_RD_LAT-1] && (op_q[MEM_RD_LAT-1] == OP_READ);
    assign mem_rrsp_data  = data_q[MEM_RD_LAT-1];
    assign mem_rrsp_id    = id_q[MEM_RD_LAT-1];
    assign mem_rrsp_err   = err_q[MEM_RD_LAT-1];

endmodule : mesh_word_bank

/* hdl/mri_drain_fifo.sv */
`timescale 1ns/1ps

// Small register-file queue that drains itself without a read strobe
// Pops when non-empty now and non-empty last cycle, valid_out marks each pop
// Pushes that find no room are dropped and latch the overflow flag

module mri_drain_fifo #(
    parameter int WIDTH = 8                     // Entry width
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr,                // Push strobe
    input  logic [WIDTH-1:0] d_in,              // Entry to push
    output logic             valid_out,         // One pulse per popped entry
    output logic [WIDTH-1:0] d_out,             // Head entry, valid with valid_out
    output logic             overflow           // Sticky until reset
);
    import mri_pkg::*;

    logic [WIDTH-1:0]      mem [FIFO_DEPTH];    // Entry storage
    logic [W_FIFO_PTR-1:0] wr_ptr;
    logic [W_FIFO_PTR-1:0] rd_ptr;
    logic [W_FIFO_CNT-1:0] count;               // Entries held
    logic                  empty;
    logic                  empty_reg;           // Empty as seen last cycle
    logic                  full;
    logic                  pop;
    logic                  push;

    // Pointer increment with wrap at the queue depth
    function automatic logic [W_FIFO_PTR-1:0] next_ptr(input logic [W_FIFO_PTR-1:0] ptr);
        return (ptr == W_FIFO_PTR'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == W_FIFO_CNT'(FIFO_DEPTH));

    // Never pops in the first cycle after turning non-empty
    assign pop  = !empty && !empty_reg;
    assign push = wr && (!full || pop);         // A pop in the same cycle frees a slot

    assign valid_out = pop;
    assign d_out     = mem[rd_ptr];

    ////////////////////////////////////////////////////////////
    // Control state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            empty_reg <= 1'b1;                  // Blocks a pop straight out of reset
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            overflow  <= 1'b0;
        end else begin
            empty_reg <= empty;
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + W_FIFO_CNT'(push) - W_FIFO_CNT'(pop);
            if (wr && !push) begin
                overflow <= 1'b1;               // Entry lost
            end
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= d_in;
        end
    end

endmodule : mri_drain_fifo

/* hdl/mri_pkg.sv */
// Shared widths, queue sizing and bank types for the mesh read interface
// Imported by the drain FIFO, the word bank and the top level

package mri_pkg;

    ////////////////////////////////////////////////////////////
    // Mesh word and segment geometry
    ////////////////////////////////////////////////////////////
    localparam int W_WORD       = 32;              // Data word width
    localparam int N_SEG        = 16;              // Segments held by the bank
    localparam int W_SEG_PTR    = $clog2(N_SEG);   // Segment pointer
    localparam int N_WD_PER_SEG = 4;               // Words in one segment
    localparam int W_WD_SEL     = 2;               // Word select within a segment
    localparam int W_SEMA       = 2;               // Segment semaphore
    localparam int W_REQ_ID     = 4;               // Request tag returned with the data

    ////////////////////////////////////////////////////////////
    // Packed queue entries
    ////////////////////////////////////////////////////////////
    // Request entry is {seg_ptr, sema, wd_sel, id}
    localparam int W_RREQ = W_SEG_PTR + W_SEMA + W_WD_SEL + W_REQ_ID;
    // Response entry is {err, id, data}
    localparam int W_RRSP = W_WORD + W_REQ_ID + 1;

    ////////////////////////////////////////////////////////////
    // Queue and bank timing
    ////////////////////////////////////////////////////////////
    localparam int FIFO_DEPTH = 4;                 // Entries per queue
    localparam int W_FIFO_PTR = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int W_FIFO_CNT = $clog2(FIFO_DEPTH + 1);  // Holds 0..FIFO_DEPTH
    localparam int MEM_RD_LAT = 2;                 // Bank read latency in cycles

    // What the bank did in a given cycle, carried down the read pipe
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,   // Nothing sampled
        OP_WRITE = 2'd1,   // Write only
        OP_READ  = 2'd2    // Read, with or without a write alongside
    } bank_op_e;

endpackage : mri_pkg

/* run.sh */
#!/usr/bin/env bash
# Builds the mesh read testbench with Verilator and runs it
# Exit status is the simulator's, nonzero on any failure
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module mesh_read_tb \
    -f src.f \
    -o mesh_read_sim

./obj_dir/mesh_read_sim

/* src.f */
hdl/mri_pkg.sv
hdl/mri_drain_fifo.sv
hdl/mesh_word_bank.sv
hdl/mesh_read_top.sv
bench/mesh_read_tb.sv
